// File: common/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define CACHE_SETS 4
`define CACHE_WORDS 4

// backing store
`define MEM_LATENCY 4
`define MEM_LINES 64

`endif

// File: common/cache_pkg.sv
package cache_pkg;

    // processor side, word addressed
    typedef struct packed {
        logic        read;
        logic        write;
        logic [29:0] addr;
        logic [31:0] wdata;
    } proc_req_t;

    // one cache line seen flat or as words
    typedef union packed {
        logic [127:0]         bits;
        logic [3:0][31:0]     words;
    } cache_line_u;

    // memory side, line addressed
    typedef struct packed {
        logic        read;
        logic        write;
        logic [27:0] addr;
        cache_line_u wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic        dirty;
        logic [25:0] tag;
    } tag_entry_t;

endpackage

// File: cache/cache_tag_array.sv
`include "cache_config.svh"

module cache_tag_array (
    input  logic        clk,
    input  logic        proc_reset,
    input  logic [1:0]  index,
    input  logic [25:0] addr_tag,
    input  logic        tag_we,
    input  logic        tag_way,
    input  logic        tag_dirty,
    input  logic        lru_touch,
    output logic        hit,
    output logic        hit_way,
    output logic        victim_way,
    output logic        victim_dirty,
    output logic [25:0] victim_tag
);

    cache_pkg::tag_entry_t tags [0:`CACHE_SETS-1][0:1];
    // lru bit names the way to replace next
    logic                  lru  [0:`CACHE_SETS-1];

    cache_pkg::tag_entry_t entry0;
    cache_pkg::tag_entry_t entry1;
    cache_pkg::tag_entry_t victim;
    logic                  hit0;
    logic                  hit1;

    assign entry0 = tags[index][0];
    assign entry1 = tags[index][1];

    assign hit0 = entry0.valid && (entry0.tag == addr_tag);
    assign hit1 = entry1.valid && (entry1.tag == addr_tag);
    assign hit = hit0 | hit1;
    assign hit_way = hit1;

    assign victim_way = lru[index];
    assign victim = tags[index][victim_way];
    // an invalid line never needs a write-back
    assign victim_dirty = victim.valid && victim.dirty;
    assign victim_tag = victim.tag;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                lru[s] <= 1'b0;
                tags[s][0] <= '0;
                tags[s][1] <= '0;
            end
        end else begin
            if (tag_we) begin
                tags[index][tag_way].valid <= 1'b1;
                tags[index][tag_way].dirty <= tag_dirty;
                tags[index][tag_way].tag <= addr_tag;
            end
            if (lru_touch) begin
                lru[index] <= ~tag_way;
            end
        end
    end

    // fills always go to the victim, so one tag lives in one way only
    a_single_hit: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(hit0 && hit1)
    ) else $error("both ways hit in set %0d", index);

endmodule

// File: cache/cache_data_array.sv
`include "cache_config.svh"

module cache_data_array (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  logic [1:0]             index,
    input  logic [1:0]             offset,
    input  logic                   way,
    input  logic                   data_we,
    input  logic                   fill_sel,
    input  logic [31:0]            wdata,
    input  logic                   write,
    input  cache_pkg::cache_line_u fill_line,
    output cache_pkg::cache_line_u line_out,
    output logic [31:0]            rdata
);

    cache_pkg::cache_line_u lines [0:`CACHE_SETS-1][0:1];
    cache_pkg::cache_line_u merged_line;

    assign line_out = lines[index][way];
    assign rdata = line_out.words[offset];

    // base line, then the processor word on top for writes
    always_comb begin
        merged_line = fill_sel ? fill_line : line_out;
        for (int w = 0; w < `CACHE_WORDS; w++) begin
            if (write && (offset == w)) begin
                merged_line.words[w] = wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            lines[index][way] <= merged_line;
        end
    end

    // request is held past the fill, so the next cycle reads the new line
    a_fill_visible: assert property (
        @(posedge clk) disable iff (proc_reset)
        (data_we && fill_sel) |=> (line_out == $past(merged_line))
    ) else $error("filled line not visible in set %0d", index);

endmodule

// File: cache/cache_ctrl.sv
module cache_ctrl (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_pkg::proc_req_t   proc_req,
    input  logic                   hit,
    input  logic                   hit_way,
    input  logic                   victim_way,
    input  logic                   victim_dirty,
    input  logic [25:0]            victim_tag,
    input  cache_pkg::cache_line_u victim_line,
    input  logic                   mem_ready,
    output cache_pkg::mem_req_t    mem_req,
    output logic                   proc_stall,
    output logic                   tag_we,
    output logic                   tag_way,
    output logic                   tag_dirty,
    output logic                   lru_touch,
    output logic                   data_we,
    output logic                   data_way,
    output logic                   fill_sel
);

    typedef enum logic [1:0] {
        IDLE,
        MISS,
        WRITE_BACK,
        ALLOCATE
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = proc_req.read | proc_req.write;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (request && !hit) begin
                    next_state = MISS;
                end
            end
            MISS: next_state = victim_dirty ? WRITE_BACK : ALLOCATE;
            WRITE_BACK: begin
                if (mem_ready) begin
                    next_state = ALLOCATE;
                end
            end
            ALLOCATE: begin
                if (mem_ready) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        mem_req = '0;
        proc_stall = 1'b1;
        tag_we = 1'b0;
        tag_way = victim_way;
        tag_dirty = 1'b0;
        lru_touch = 1'b0;
        data_we = 1'b0;
        data_way = victim_way;
        fill_sel = 1'b0;
        case (state)
            IDLE: begin
                // hits finish here in one cycle
                proc_stall = request && !hit;
                tag_way = hit_way;
                data_way = hit_way;
                tag_we = proc_req.write && hit;
                tag_dirty = 1'b1;
                data_we = proc_req.write && hit;
                lru_touch = request && hit;
            end
            WRITE_BACK: begin
                mem_req.write = 1'b1;
                mem_req.addr = {victim_tag, proc_req.addr[3:2]};
                mem_req.wdata = victim_line;
            end
            ALLOCATE: begin
                mem_req.read = 1'b1;
                mem_req.addr = proc_req.addr[29:2];
                // fill and merge in one go when the line arrives
                tag_we = mem_ready;
                tag_dirty = proc_req.write;
                lru_touch = mem_ready;
                data_we = mem_ready;
                fill_sel = 1'b1;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    a_mem_req_legal: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_req.read && mem_req.write) &&
        ((state != IDLE) || !(mem_req.read || mem_req.write))
    ) else $error("illegal memory request in state %s", state.name());

endmodule

// File: cache/cache.sv
module cache (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_pkg::proc_req_t   proc_req,
    output logic [31:0]            proc_rdata,
    output logic                   proc_stall,
    output cache_pkg::mem_req_t    mem_req,
    input  cache_pkg::cache_line_u mem_rdata,
    input  logic                   mem_ready
);

    // word address is tag | index | offset
    logic [25:0] addr_tag;
    logic [1:0]  addr_index;
    logic [1:0]  addr_offset;

    logic        hit;
    logic        hit_way;
    logic        victim_way;
    logic        victim_dirty;
    logic [25:0] victim_tag;

    logic        tag_we;
    logic        tag_way;
    logic        tag_dirty;
    logic        lru_touch;
    logic        data_we;
    logic        data_way;
    logic        fill_sel;

    cache_pkg::cache_line_u line_out;

    assign addr_tag = proc_req.addr[29:4];
    assign addr_index = proc_req.addr[3:2];
    assign addr_offset = proc_req.addr[1:0];

    cache_tag_array u_tag_array (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (addr_index),
        .addr_tag     (addr_tag),
        .tag_we       (tag_we),
        .tag_way      (tag_way),
        .tag_dirty    (tag_dirty),
        .lru_touch    (lru_touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_array u_data_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (addr_index),
        .offset     (addr_offset),
        .way        (data_way),
        .data_we    (data_we),
        .fill_sel   (fill_sel),
        .wdata      (proc_req.wdata),
        .write      (proc_req.write),
        .fill_line  (mem_rdata),
        .line_out   (line_out),
        .rdata      (proc_rdata)
    );

    // line_out is the victim outside IDLE, so it feeds the write-back
    cache_ctrl u_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_req     (proc_req),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (line_out),
        .mem_ready    (mem_ready),
        .mem_req      (mem_req),
        .proc_stall   (proc_stall),
        .tag_we       (tag_we),
        .tag_way      (tag_way),
        .tag_dirty    (tag_dirty),
        .lru_touch    (lru_touch),
        .data_we      (data_we),
        .data_way     (data_way),
        .fill_sel     (fill_sel)
    );

endmodule

// File: rtl/main_memory.sv
`include "cache_config.svh"

module main_memory (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_pkg::mem_req_t    mem_req,
    output cache_pkg::cache_line_u mem_rdata,
    output logic                   mem_ready
);

    localparam int LINE_BITS = $clog2(`MEM_LINES);
    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

    cache_pkg::cache_line_u lines [0:`MEM_LINES-1];

    logic [LINE_BITS-1:0] line_idx;
    logic [CNT_BITS-1:0]  count;
    logic                 busy;

    // upper address bits alias onto the same lines
    assign line_idx = mem_req.addr[LINE_BITS-1:0];
    assign busy = mem_req.read | mem_req.write;

    // ready in the last cycle of the held request
    assign mem_ready = busy && (count == CNT_BITS'(`MEM_LATENCY - 1));
    assign mem_rdata = lines[line_idx];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            count <= '0;
            for (int i = 0; i < `MEM_LINES; i++) begin
                lines[i] <= '0;
            end
        end else begin
            if (!busy || mem_ready) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            if (mem_ready && mem_req.write) begin
                lines[line_idx] <= mem_req.wdata;
            end
        end
    end

    a_req_held: assert property (
        @(posedge clk) disable iff (proc_reset)
        (busy && !mem_ready) |=> $stable(mem_req)
    ) else $error("memory request changed before ready");

endmodule

// File: rtl/mem_system.sv
module mem_system (
    input  logic                 clk,
    input  logic                 proc_reset,
    input  cache_pkg::proc_req_t proc_req,
    output logic [31:0]          proc_rdata,
    output logic                 proc_stall
);

    cache_pkg::mem_req_t    mem_req;
    cache_pkg::cache_line_u mem_rdata;
    logic                   mem_ready;

    cache u_cache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    main_memory u_main_memory (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

endmodule

// File: bench/tb_mem_system.sv
`include "cache_config.svh"

module tb_mem_system;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MODEL_WORDS = `MEM_LINES * `CACHE_WORDS;
    localparam int CLEAN_STALL = 2 + `MEM_LATENCY;
    localparam int DIRTY_STALL = 2 + 2 * `MEM_LATENCY;
    localparam int RANDOM_OPS = 2000;
    localparam int OP_COUNT = 32 + 40 + 36 + 32 + RANDOM_OPS;
    localparam int CLK_PERIOD = 20;

    logic                 clk;
    logic                 proc_reset;
    cache_pkg::proc_req_t proc_req;
    logic [31:0]          proc_rdata;
    logic                 proc_stall;

    // flat word image of what memory should hold
    logic [31:0] model_mem [0:MODEL_WORDS-1];
    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_errors;
    int          stall_errors;
    int          hit_ops;
    int          clean_ops;
    int          dirty_ops;

    mem_system UUT (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // worst case per op is a dirty miss plus a little slack, doubled
    initial begin
        #(OP_COUNT * (4 + 2 * `MEM_LATENCY) * CLK_PERIOD * 2);
        $display("timeout: the operations did not all complete in the allowed time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [29:0] random_word_addr(input int lines);
        logic [27:0] line;
        logic [1:0]  offset;
        line = 28'(take_bits(8) % lines);
        offset = 2'(take_bits(2));
        return {line, offset};
    endfunction

    task automatic check_rdata(input logic [29:0] addr, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Error at time %0d ns: proc_rdata = %h, expected %h (word address %h)",
                     $time, got, expected, addr);
        end
    endtask

    task automatic check_stall_cycles(input int cycles, input bit must_hit);
        bit legal;
        check_count++;
        if (must_hit) begin
            legal = (cycles == 0);
        end else begin
            legal = (cycles == 0) || (cycles == CLEAN_STALL) || (cycles == DIRTY_STALL);
        end
        if (!legal) begin
            error_count++;
            stall_errors++;
            if (must_hit) begin
                $display("Error at time %0d ns: proc_stall cycles = %0d, expected 0",
                         $time, cycles);
            end else begin
                $display("Error at time %0d ns: proc_stall cycles = %0d, expected 0, %0d or %0d",
                         $time, cycles, CLEAN_STALL, DIRTY_STALL);
            end
        end else if (cycles == 0) begin
            hit_ops++;
        end else if (cycles == CLEAN_STALL) begin
            clean_ops++;
        end else begin
            dirty_ops++;
        end
    endtask

    // called on a rising edge, returns on the edge where the request completes
    task automatic run_op(input logic is_write, input logic [29:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int stalls);
        cache_pkg::proc_req_t req;
        req.read = !is_write;
        req.write = is_write;
        req.addr = addr;
        req.wdata = wdata;
        proc_req <= req;
        stalls = 0;
        @(negedge clk);
        while (proc_stall && (stalls <= DIRTY_STALL)) begin
            stalls++;
            @(negedge clk);
        end
        rdata = proc_rdata;
        @(posedge clk);
    endtask

    task automatic do_read(input logic [29:0] addr, input bit must_hit);
        logic [31:0] rdata;
        int          stalls;
        run_op(1'b0, addr, '0, rdata, stalls);
        check_stall_cycles(stalls, must_hit);
        check_rdata(addr, rdata, model_mem[addr]);
    endtask

    task automatic do_write(input logic [29:0] addr, input logic [31:0] data,
                            input bit must_hit);
        logic [31:0] rdata;
        int          stalls;
        run_op(1'b1, addr, data, rdata, stalls);
        check_stall_cycles(stalls, must_hit);
        model_mem[addr] = data;
    endtask

    task automatic idle_cycle();
        proc_req <= '0;
        @(posedge clk);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d, %s: %0d errors", test_count, name, error_count - test_errors);
        test_errors = error_count;
    endtask

    initial begin : stimulus
        logic [29:0] addr;
        logic [31:0] data;
        logic [27:0] set_lines [0:2];
        proc_reset = 1'b1;
        proc_req = '0;
        lfsr = 32'h8a5f119f;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        test_errors = 0;
        stall_errors = 0;
        hit_ops = 0;
        clean_ops = 0;
        dirty_ops = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (8) @(posedge clk);
        proc_reset <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < 32; i++) begin
            do_read(random_word_addr(`MEM_LINES), 1'b0);
        end
        idle_cycle();
        report_test("reads after reset");

        // one word written, then the whole line read back
        for (int i = 0; i < 8; i++) begin
            addr = random_word_addr(`MEM_LINES);
            data = take_bits(32);
            do_write(addr, data, 1'b0);
            for (int w = 0; w < `CACHE_WORDS; w++) begin
                do_read({addr[29:2], 2'(w)}, 1'b0);
            end
        end
        idle_cycle();
        report_test("write then read");

        // lines 6, 22 and 38 all land in set 2
        set_lines[0] = 28'd6;
        set_lines[1] = 28'd22;
        set_lines[2] = 28'd38;
        for (int r = 0; r < 4; r++) begin
            for (int t = 0; t < 3; t++) begin
                addr = {set_lines[t], 2'(take_bits(2))};
                data = take_bits(32);
                do_write(addr, data, 1'b0);
                do_read(addr, 1'b0);
            end
        end
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < `CACHE_WORDS; w++) begin
                do_read({set_lines[t], 2'(w)}, 1'b0);
            end
        end
        idle_cycle();
        report_test("dirty evictions in one set");

        // second of each pair must hit
        for (int i = 0; i < 16; i++) begin
            addr = random_word_addr(`MEM_LINES);
            if (take_bits(1) != 0) begin
                data = take_bits(32);
                do_write(addr, data, 1'b0);
                do_write(addr, data, 1'b1);
            end else begin
                do_read(addr, 1'b0);
                do_read(addr, 1'b1);
            end
        end
        idle_cycle();
        report_test("back to back repeats");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            addr = random_word_addr(24);
            if (take_bits(1) != 0) begin
                do_write(addr, take_bits(32), 1'b0);
            end else begin
                do_read(addr, 1'b0);
            end
        end
        idle_cycle();
        report_test("random stream");

        $display("%0d tests, %0d checks, %0d errors (%0d stall), hits %0d, clean %0d, dirty %0d",
                 test_count, check_count, error_count, stall_errors,
                 hit_ops, clean_ops, dirty_ops);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/cache_pkg.sv
cache/cache_tag_array.sv
cache/cache_data_array.sv
cache/cache_ctrl.sv
cache/cache.sv
rtl/main_memory.sv
rtl/mem_system.sv
bench/tb_mem_system.sv
